/* ftdi_bridge_top.f */
rtl/bridge_pkg.sv
rtl/uart_rx.sv
rtl/pkt_assembler.sv
rtl/pkt_fifo.sv
rtl/uart_tx.sv
rtl/link_router.sv
rtl/status_led.sv
rtl/ftdi_bridge_top.sv
bench/tb_clk_gen.sv
bench/tb_ftdi_bridge.sv

/* bench/tb_ftdi_bridge.sv */
/*
 * Self-checking testbench for ftdi_bridge_top with host UART and link models.
 * Fixed-seed random packets. Inputs change 2 ns after the rising edge.
 * Monitors sample on the falling edge. A watchdog bounds the run.
 */
`timescale 1ns/1ps

module tb_ftdi_bridge
	import bridge_pkg::*;
();

	localparam int H2L_PKTS    = 20;
	localparam int L2H_PKTS    = 10;
	localparam int BP_PKTS     = 8;
	localparam int TEST_PKTS   = H2L_PKTS + L2H_PKTS + BP_PKTS + 1; // Last one after framing error
	localparam int PKT_CLKS    = PKT_BYTES * FRAME_BITS * BAUD_PERIOD; // One packet on the UART
	localparam int CLK_NS      = 20;
	localparam int WATCHDOG_NS = 4 * TEST_PKTS * PKT_CLKS * CLK_NS;

	logic       clk;
	logic       rst_n;
	logic       uart_rx;
	logic       uart_tx;
	logic       uart_cts_n;
	pkt_t       link_tx_data;
	logic       link_tx_vld;
	logic       link_tx_rdy;
	pkt_t       link_rx_data;
	chan_t      link_rx_chan;
	logic       link_rx_vld;
	logic       link_rx_rdy;
	logic       link_connected;
	logic       link_mismatch;
	logic [1:0] led;

	integer seed      = 32'h8ec7eaa2;
	int     err_cnt   = 0;
	int     check_cnt = 0;
	pkt_t   link_exp [$]; // Expected on link_tx_data_o in order
	pkt_t   uart_exp [$]; // Expected on uart_tx_o in order

	tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (.clk_o(clk));

	ftdi_bridge_top ftdi_bridge_top_i (
		.clk_i            (clk),
		.rst_n_i          (rst_n),
		.uart_rx_i        (uart_rx),
		.uart_tx_o        (uart_tx),
		.uart_cts_n_o     (uart_cts_n),
		.link_tx_data_o   (link_tx_data),
		.link_tx_vld_o    (link_tx_vld),
		.link_tx_rdy_i    (link_tx_rdy),
		.link_rx_data_i   (link_rx_data),
		.link_rx_chan_i   (link_rx_chan),
		.link_rx_vld_i    (link_rx_vld),
		.link_rx_rdy_o    (link_rx_rdy),
		.link_connected_i (link_connected),
		.link_mismatch_i  (link_mismatch),
		.led_o            (led)
	);

	//////////////////////////////////////////////////
	// Reference functions and check helpers
	//////////////////////////////////////////////////

	// Byte idx of a packet where byte 0 is sent first
	function automatic byte_t pkt_byte(input pkt_t p, input int idx);
		return byte_t'(p >> (8 * idx));
	endfunction

	function automatic pkt_t join_bytes(input byte_t b [PKT_BYTES]);
		pkt_t p;
		p = '0;
		for (int i = 0; i < PKT_BYTES; i++)
			p = p | (pkt_t'(b[i]) << (8 * i)); // First byte lowest
		return p;
	endfunction

	function automatic pkt_t rand_pkt();
		pkt_t p;
		p[31:0]          = $random(seed);
		p[PKT_BITS-1:32] = $random(seed); // Upper byte only
		return p;
	endfunction

	task automatic note_failure(input string what);
		err_cnt++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	task automatic check_value(input string name, input logic [PKT_BITS-1:0] exp,
		input logic [PKT_BITS-1:0] got);
		check_cnt++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s exp=%h got=%h", name, exp, got);
			err_cnt++;
		end
	endtask

	//////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#2; // Drive point
	endtask

	task automatic hold_bit();
		repeat (BAUD_PERIOD) next_cycle();
	endtask

	// Host UART frame with one idle bit after a low stop bit
	task automatic send_frame(input byte_t b, input logic stop_val);
		uart_rx = 1'b0;
		hold_bit();
		for (int i = 0; i < 8; i++)
		begin
			uart_rx = b[i]; // LSB first
			hold_bit();
		end
		uart_rx = stop_val;
		hold_bit();
		if (!stop_val)
		begin
			uart_rx = 1'b1; // Line back to idle for the next start edge
			hold_bit();
		end
	endtask

	task automatic send_host_pkt();
		byte_t bytes [PKT_BYTES];
		for (int i = 0; i < PKT_BYTES; i++)
			bytes[i] = byte_t'($random(seed));
		link_exp.push_back(join_bytes(bytes));
		for (int i = 0; i < PKT_BYTES; i++)
			send_frame(bytes[i], 1'b1);
	endtask

	// Holds valid and data until the transfer edge
	task automatic send_link_pkt(input pkt_t p, input chan_t c);
		link_rx_data = p;
		link_rx_chan = c;
		link_rx_vld  = 1'b1;
		@(negedge clk);
		if (c != '0)
			check_value("link_rx_rdy_o", 1, link_rx_rdy); // Sink is always ready
		while (!link_rx_rdy)
			@(negedge clk);
		next_cycle();
		link_rx_vld = 1'b0;
	endtask

	task automatic wait_drain(input int max_clks);
		int n;
		n = 0;
		while ((link_exp.size() != 0 || uart_exp.size() != 0) && n < max_clks)
		begin
			next_cycle();
			n++;
		end
		check_cnt++;
		assert (link_exp.size() == 0 && uart_exp.size() == 0)
		else
			note_failure("expected packets did not arrive in time");
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	// Outgoing link transfers at the next rising edge
	initial
	begin
		wait (rst_n === 1'b1);
		forever
		begin
			@(negedge clk);
			if (link_tx_vld === 1'b1 && link_tx_rdy === 1'b1)
			begin
				check_cnt++;
				assert (link_exp.size() != 0)
				else
					note_failure("packet on link_tx_data_o with none expected");
				if (link_exp.size() != 0)
					check_value("link_tx_data_o", link_exp.pop_front(), link_tx_data);
			end
		end
	end

	// Host side receiver on uart_tx_o sampling at mid-bit
	initial
	begin
		byte_t rx_bytes [PKT_BYTES];
		int    nbytes;
		pkt_t  exp;
		nbytes = 0;
		wait (rst_n === 1'b1);
		forever
		begin
			@(negedge clk);
			if (uart_tx === 1'b0)
			begin
				repeat (BAUD_PERIOD / 2) @(negedge clk); // Middle of start bit
				check_cnt++;
				assert (uart_tx === 1'b0)
				else
					note_failure("start bit on uart_tx_o ended early");
				for (int i = 0; i < 8; i++)
				begin
					repeat (BAUD_PERIOD) @(negedge clk);
					rx_bytes[nbytes][i] = uart_tx;
				end
				repeat (BAUD_PERIOD) @(negedge clk);
				check_value("uart_tx_o stop bit", 1, uart_tx);
				nbytes++;
				if (nbytes == PKT_BYTES)
				begin
					nbytes = 0;
					check_cnt++;
					assert (uart_exp.size() != 0)
					else
						note_failure("packet on uart_tx_o with none expected");
					if (uart_exp.size() != 0)
					begin
						exp = uart_exp.pop_front();
						for (int i = 0; i < PKT_BYTES; i++)
							check_value($sformatf("uart_tx_o byte %0d", i),
								pkt_byte(exp, i), rx_bytes[i]);
					end
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		pkt_t p;
		int   n;
		logic seen_lo;
		logic seen_hi;
		uart_rx        = 1'b1; // Idle line
		link_tx_rdy    = 1'b0;
		link_rx_data   = '0;
		link_rx_chan   = '0;
		link_rx_vld    = 1'b0;
		link_connected = 1'b0;
		link_mismatch  = 1'b0;
		rst_n          = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Reset values
		@(negedge clk);
		check_value("uart_tx_o", 1, uart_tx);
		check_value("link_tx_vld_o", 0, link_tx_vld);
		check_value("uart_cts_n_o", 0, uart_cts_n);
		check_value("led_o", 0, led);
		check_value("link_rx_rdy_o", 1, link_rx_rdy);
		next_cycle();

		// Host to link
		link_tx_rdy = 1'b1;
		repeat (H2L_PKTS) send_host_pkt();
		wait_drain(PKT_CLKS);

		// Link to host with other channels interleaved
		for (int i = 0; i < L2H_PKTS; i++)
		begin
			send_link_pkt(rand_pkt(), chan_t'(1 + {$random(seed)} % 7));
			p = rand_pkt();
			uart_exp.push_back(p);
			send_link_pkt(p, '0);
		end
		wait_drain(2 * PKT_CLKS);

		// Line must stay quiet while LED 1 still shows the UART traffic
		seen_lo = 1'b0;
		seen_hi = 1'b0;
		repeat (PKT_CLKS)
		begin
			@(negedge clk);
			if (led[1])
				seen_hi = 1'b1;
			else
				seen_lo = 1'b1;
		end
		check_cnt++;
		assert (seen_lo && seen_hi)
		else
			note_failure("led_o[1] did not blink after UART traffic");
		next_cycle();

		// Back-pressure fills the FIFO to the high-water mark
		link_tx_rdy = 1'b0;
		repeat (BP_PKTS - 1) send_host_pkt();
		check_value("uart_cts_n_o", 0, uart_cts_n);
		send_host_pkt();
		n = 0;
		while (!uart_cts_n && n < 4 * BAUD_PERIOD)
		begin
			next_cycle();
			n++;
		end
		check_cnt++;
		assert (uart_cts_n === 1'b1)
		else
			note_failure("uart_cts_n_o stayed low at the high-water mark");
		check_cnt++;
		assert (link_exp.size() == BP_PKTS)
		else
			note_failure("packets left the FIFO while link_tx_rdy_i was low");
		repeat (BAUD_PERIOD) next_cycle();
		link_tx_rdy = 1'b1;
		wait_drain(PKT_CLKS);
		check_value("uart_cts_n_o", 0, uart_cts_n);

		// Bad stop bit mid-packet, then one full packet
		send_frame(byte_t'($random(seed)), 1'b1);
		send_frame(byte_t'($random(seed)), 1'b1);
		send_frame(byte_t'($random(seed)), 1'b0);
		send_host_pkt();
		wait_drain(PKT_CLKS);
		repeat (PKT_CLKS) next_cycle(); // Nothing else may appear

		// LED 0 steady when connected and idle
		link_connected = 1'b1;
		repeat (ACTIVITY_TIMEOUT + 64) next_cycle();
		repeat (128)
		begin
			@(negedge clk);
			check_value("led_o[0]", 1, led[0]);
		end
		next_cycle();

		// Mismatch blinks
		link_mismatch = 1'b1;
		seen_lo = 1'b0;
		seen_hi = 1'b0;
		repeat (128)
		begin
			@(negedge clk);
			if (led[0])
				seen_hi = 1'b1;
			else
				seen_lo = 1'b1;
		end
		check_cnt++;
		assert (seen_lo && seen_hi)
		else
			note_failure("led_o[0] did not blink with link_mismatch_i high");
		next_cycle();

		// LED 0 off when disconnected
		link_mismatch  = 1'b0;
		link_connected = 1'b0;
		repeat (2) next_cycle();
		repeat (64)
		begin
			@(negedge clk);
			check_value("led_o[0]", 0, led[0]);
		end

		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* bench/tb_clk_gen.sv */
/*
 * Free-running testbench clock that starts low. PERIOD_NS should be even.
 */
`timescale 1ns/1ps

module tb_clk_gen
#(
	parameter int PERIOD_NS = 20
)
(
	output logic clk_o
);

	initial
		clk_o = 1'b0;

	always #(PERIOD_NS / 2) clk_o = ~clk_o; // Half period per phase

endmodule

/* rtl/ftdi_bridge_top.sv */
/*
 * Host UART to SpiNNaker packet link bridge, single clock domain.
 * Link handshake is external; only its status levels come in here.
 */
`timescale 1ns/1ps

module ftdi_bridge_top import bridge_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,
	// Host UART
	input  logic       uart_rx_i,
	output logic       uart_tx_o,
	output logic       uart_cts_n_o,    // Low while host may send
	// Outgoing link, channel 0 only
	output pkt_t       link_tx_data_o,
	output logic       link_tx_vld_o,
	input  logic       link_tx_rdy_i,
	// Incoming link
	input  pkt_t       link_rx_data_i,
	input  chan_t      link_rx_chan_i,
	input  logic       link_rx_vld_i,
	output logic       link_rx_rdy_o,
	// Status
	input  logic       link_connected_i,
	input  logic       link_mismatch_i,
	output logic [1:0] led_o
);

	byte_t rx_byte;
	logic  rx_byte_stb;
	logic  rx_frame_err_stb;
	pkt_t  pkt_push_data;
	logic  pkt_push_stb;
	pkt_t  host_pkt_data;
	logic  host_pkt_vld;
	logic  host_pkt_rdy;
	logic  link_activity_stb;
	logic  uart_activity_stb;

	//////////////////////////////////////////////////
	// Host to link
	//////////////////////////////////////////////////

	uart_rx u_uart_rx (
		.clk_i              (clk_i),
		.rst_n_i            (rst_n_i),
		.uart_rx_i          (uart_rx_i),
		.rx_byte_o          (rx_byte),
		.rx_byte_stb_o      (rx_byte_stb),
		.rx_frame_err_stb_o (rx_frame_err_stb)
	);

	pkt_assembler u_pkt_assembler (
		.clk_i              (clk_i),
		.rst_n_i            (rst_n_i),
		.rx_byte_i          (rx_byte),
		.rx_byte_stb_i      (rx_byte_stb),
		.rx_frame_err_stb_i (rx_frame_err_stb),
		.pkt_push_data_o    (pkt_push_data),
		.pkt_push_stb_o     (pkt_push_stb)
	);

	pkt_fifo #(
		.ADDR_BITS  (RX_FIFO_ADDR_BITS),
		.HIGH_WATER (RX_HIGH_WATER_MARK)
	) u_pkt_fifo (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.push_data_i   (pkt_push_data),
		.push_stb_i    (pkt_push_stb),
		.pop_data_o    (link_tx_data_o),
		.pop_vld_o     (link_tx_vld_o),
		.pop_rdy_i     (link_tx_rdy_i),
		.almost_full_o (uart_cts_n_o)   // CTS deasserted at high water
	);

	//////////////////////////////////////////////////
	// Link to host
	//////////////////////////////////////////////////

	link_router u_link_router (
		.clk_i               (clk_i),
		.rst_n_i             (rst_n_i),
		.link_rx_data_i      (link_rx_data_i),
		.link_rx_chan_i      (link_rx_chan_i),
		.link_rx_vld_i       (link_rx_vld_i),
		.link_rx_rdy_o       (link_rx_rdy_o),
		.link_tx_vld_i       (link_tx_vld_o),
		.link_tx_rdy_i       (link_tx_rdy_i),
		.host_pkt_data_o     (host_pkt_data),
		.host_pkt_vld_o      (host_pkt_vld),
		.host_pkt_rdy_i      (host_pkt_rdy),
		.link_activity_stb_o (link_activity_stb),
		.uart_activity_stb_o (uart_activity_stb)
	);

	uart_tx u_uart_tx (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.pkt_data_i (host_pkt_data),
		.pkt_vld_i  (host_pkt_vld),
		.pkt_rdy_o  (host_pkt_rdy),
		.uart_tx_o  (uart_tx_o)
	);

	// LED 0 link, LED 1 UART
	status_led u_status_led (
		.clk_i               (clk_i),
		.rst_n_i             (rst_n_i),
		.link_connected_i    (link_connected_i),
		.link_mismatch_i     (link_mismatch_i),
		.link_activity_stb_i (link_activity_stb),
		.uart_activity_stb_i (uart_activity_stb),
		.led_o               (led_o)
	);

endmodule

/* rtl/status_led.sv */
/*
 * LED 0 shows link state, LED 1 shows UART traffic. No PWM.
 * Blink phase comes from a free-running counter, so latency varies.
 */
`timescale 1ns/1ps

module status_led import bridge_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       link_connected_i,
	input  logic       link_mismatch_i,
	input  logic       link_activity_stb_i,
	input  logic       uart_activity_stb_i,
	output logic [1:0] led_o
);

	logic [1:0]               act_stb;    // [0] link, [1] UART
	logic [ACTIVITY_BITS-1:0] tmr_q [2];  // Clocks left of activity status
	logic [BLINK_BIT:0]       blink_cnt_q;
	logic                     blink;
	logic                     link_active;
	logic                     uart_active;
	logic [1:0]               led_q;

	assign act_stb = {uart_activity_stb_i, link_activity_stb_i};

	//////////////////////////////////////////////////
	// Activity timers and blink counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			blink_cnt_q <= '0;
			for (int i = 0; i < 2; i++)
				tmr_q[i] <= '0;
		end
		else
		begin
			blink_cnt_q <= blink_cnt_q + 1'b1; // Free running
			for (int i = 0; i < 2; i++)
			begin
				if (act_stb[i])
					tmr_q[i] <= ACTIVITY_BITS'(ACTIVITY_TIMEOUT); // Reload on transfer
				else if (tmr_q[i] != '0)
					tmr_q[i] <= tmr_q[i] - 1'b1;
			end
		end
	end

	assign blink       = blink_cnt_q[BLINK_BIT];
	assign link_active = (tmr_q[0] != '0);
	assign uart_active = (tmr_q[1] != '0);

	//////////////////////////////////////////////////
	// LED patterns
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
			led_q <= 2'b00;
		else
		begin
			if (link_mismatch_i)
				led_q[0] <= blink; // Version mismatch wins
			else if (!link_connected_i)
				led_q[0] <= 1'b0;
			else
				led_q[0] <= link_active ? blink : 1'b1; // Steady when idle
			led_q[1] <= uart_active && blink;
		end
	end

	assign led_o = led_q;

endmodule

/* rtl/link_router.sv */
/*
 * Channel 0 goes to the host UART, channels 1 to 7 are accepted and dropped.
 * Activity strobes lag the transfer by one clock.
 */
`timescale 1ns/1ps

module link_router import bridge_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  pkt_t  link_rx_data_i,
	input  chan_t link_rx_chan_i,
	input  logic  link_rx_vld_i,
	output logic  link_rx_rdy_o,
	input  logic  link_tx_vld_i,      // Observed only, for activity
	input  logic  link_tx_rdy_i,
	output pkt_t  host_pkt_data_o,
	output logic  host_pkt_vld_o,
	input  logic  host_pkt_rdy_i,
	output logic  link_activity_stb_o,
	output logic  uart_activity_stb_o
);

	logic chan0;
	logic host_xfer;
	logic link_tx_xfer;
	logic link_act_q;
	logic uart_act_q;

	assign chan0           = (link_rx_chan_i == '0);
	assign host_pkt_data_o = link_rx_data_i;
	assign host_pkt_vld_o  = link_rx_vld_i && chan0;
	assign link_rx_rdy_o   = chan0 ? host_pkt_rdy_i : 1'b1; // Other channels sink

	assign host_xfer    = host_pkt_vld_o && host_pkt_rdy_i;
	assign link_tx_xfer = link_tx_vld_i && link_tx_rdy_i; // FIFO pop

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			link_act_q <= 1'b0;
			uart_act_q <= 1'b0;
		end
		else
		begin
			link_act_q <= (link_rx_vld_i && link_rx_rdy_o) || link_tx_xfer; // Either direction
			uart_act_q <= host_xfer || link_tx_xfer;
		end
	end

	assign link_activity_stb_o = link_act_q;
	assign uart_activity_stb_o = uart_act_q;

	// Link must hold a stalled channel 0 packet until the UART takes it
	a_host_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		host_pkt_vld_o && !host_pkt_rdy_i |=> host_pkt_vld_o && $stable(host_pkt_data_o));

endmodule

/* rtl/uart_tx.sv */
/*
 * Sends one packet as PKT_BYTES back-to-back 8N1 frames, low byte first.
 * One packet in flight; ready only while idle.
 */
`timescale 1ns/1ps

module uart_tx import bridge_pkg::*;
(
	input  logic clk_i,
	input  logic rst_n_i,
	input  pkt_t pkt_data_i,
	input  logic pkt_vld_i,
	output logic pkt_rdy_o,
	output logic uart_tx_o   // Idles high
);

	logic                      busy_q;
	logic                      tx_q;
	pkt_t                      pkt_q;      // Remaining bytes, current one at [7:0]
	logic [BAUD_BITS-1:0]      baud_cnt_q; // Clocks left in this bit
	logic [FRAME_CNT_BITS-1:0] bit_cnt_q;  // 0 start, 1..8 data, 9 stop
	logic [BYTE_CNT_BITS-1:0]  byte_cnt_q;
	logic                      accept;
	logic                      bit_done;

	assign accept   = pkt_vld_i && !busy_q;
	assign bit_done = busy_q && (baud_cnt_q == '0);

	//////////////////////////////////////////////////
	// Frame sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			busy_q     <= 1'b0;
			tx_q       <= 1'b1;
			baud_cnt_q <= '0;
			bit_cnt_q  <= '0;
			byte_cnt_q <= '0;
		end
		else if (accept)
		begin
			busy_q     <= 1'b1;
			tx_q       <= 1'b0; // Start bit of first frame
			baud_cnt_q <= BAUD_BITS'(BAUD_PERIOD - 1);
			bit_cnt_q  <= '0;
			byte_cnt_q <= '0;
		end
		else if (busy_q && !bit_done)
			baud_cnt_q <= baud_cnt_q - 1'b1;
		else if (bit_done)
		begin
			baud_cnt_q <= BAUD_BITS'(BAUD_PERIOD - 1);
			if (bit_cnt_q == FRAME_CNT_BITS'(FRAME_BITS - 1))
			begin
				// End of stop bit
				bit_cnt_q <= '0;
				if (byte_cnt_q == BYTE_CNT_BITS'(PKT_BYTES - 1))
					busy_q <= 1'b0; // Line stays high, ready returns
				else
				begin
					byte_cnt_q <= byte_cnt_q + 1'b1;
					tx_q       <= 1'b0; // Next start bit, no gap
				end
			end
			else
			begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == FRAME_CNT_BITS'(FRAME_BITS - 2))
					tx_q <= 1'b1; // Stop bit
				else
					tx_q <= pkt_q[bit_cnt_q[2:0]]; // Data, LSB first
			end
		end
	end

	// Packet shift register, next byte moves down after each frame
	always_ff @(posedge clk_i)
	begin
		if (accept)
			pkt_q <= pkt_data_i;
		else if (bit_done && (bit_cnt_q == FRAME_CNT_BITS'(FRAME_BITS - 1)))
			pkt_q <= {8'h00, pkt_q[PKT_BITS-1:8]};
	end

	assign pkt_rdy_o = !busy_q;
	assign uart_tx_o = tx_q;

endmodule

/* rtl/pkt_fifo.sv */
/*
 * Circular packet buffer of 2**ADDR_BITS entries, push and pop in one cycle.
 * Pushing into a full buffer is illegal and the packet is lost.
 */
`timescale 1ns/1ps

module pkt_fifo import bridge_pkg::*;
#(
	parameter int ADDR_BITS  = RX_FIFO_ADDR_BITS,
	parameter int HIGH_WATER = RX_HIGH_WATER_MARK
)
(
	input  logic clk_i,
	input  logic rst_n_i,
	input  pkt_t push_data_i,
	input  logic push_stb_i,
	output pkt_t pop_data_o,
	output logic pop_vld_o,     // Non-empty
	input  logic pop_rdy_i,
	output logic almost_full_o  // Registered, occupancy >= HIGH_WATER
);

	pkt_t                 mem [2**ADDR_BITS]; // Packet storage
	logic [ADDR_BITS-1:0] wr_ptr_q;
	logic [ADDR_BITS-1:0] rd_ptr_q;
	logic [ADDR_BITS:0]   count_q;   // One extra bit for full
	logic [ADDR_BITS:0]   count_nxt;
	logic                 full;
	logic                 push;
	logic                 pop;
	logic                 af_q;

	assign full       = count_q[ADDR_BITS];
	assign push       = push_stb_i && !full;
	assign pop_vld_o  = (count_q != '0);
	assign pop        = pop_vld_o && pop_rdy_i;
	assign pop_data_o = mem[rd_ptr_q]; // Head of queue

	//////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////

	always_comb
	begin
		unique case ({push, pop})
			2'b10:   count_nxt = count_q + 1'b1;
			2'b01:   count_nxt = count_q - 1'b1;
			default: count_nxt = count_q; // Idle, or push and pop together
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			af_q     <= 1'b0;
		end
		else
		begin
			count_q <= count_nxt;
			af_q    <= (count_nxt >= HIGH_WATER); // Tracks next occupancy
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (push)
			mem[wr_ptr_q] <= push_data_i;
	end

	assign almost_full_o = af_q;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Host overran the buffer despite CTS
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_stb_i |-> !full);

	// Stalled head must hold for the link
	a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pop_vld_o && !pop_rdy_i |=> pop_vld_o && $stable(pop_data_o));

endmodule

/* rtl/pkt_assembler.sv */
/*
 * Builds packets from UART bytes, first byte in the low bits.
 * No back-pressure. The host is expected to honour clear-to-send.
 */
`timescale 1ns/1ps

module pkt_assembler import bridge_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  byte_t rx_byte_i,
	input  logic  rx_byte_stb_i,
	input  logic  rx_frame_err_stb_i, // Realigns to a packet boundary
	output pkt_t  pkt_push_data_o,
	output logic  pkt_push_stb_o
);

	logic [BYTE_CNT_BITS-1:0] byte_cnt_q;
	pkt_t                     pkt_q;    // Packet being built
	logic                     push_q;
	logic                     last_byte;

	assign last_byte = (byte_cnt_q == BYTE_CNT_BITS'(PKT_BYTES - 1));

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			byte_cnt_q <= '0;
			push_q     <= 1'b0;
		end
		else
		begin
			push_q <= rx_byte_stb_i && last_byte; // Push the cycle after byte 5
			if (rx_frame_err_stb_i)
				byte_cnt_q <= '0; // Partial packet abandoned
			else if (rx_byte_stb_i)
				byte_cnt_q <= last_byte ? '0 : byte_cnt_q + 1'b1;
		end
	end

	// Shift right so the first byte ends up at [7:0]
	always_ff @(posedge clk_i)
	begin
		if (rx_byte_stb_i)
			pkt_q <= {rx_byte_i, pkt_q[PKT_BITS-1:8]};
	end

	assign pkt_push_data_o = pkt_q;
	assign pkt_push_stb_o  = push_q;

endmodule

/* rtl/uart_rx.sv */
/*
 * 8N1 receiver at BAUD_PERIOD clocks per bit, no parity, line idles high.
 * A frame with a low stop bit is reported and its byte is not delivered.
 */
`timescale 1ns/1ps

module uart_rx import bridge_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  logic  uart_rx_i,          // Async serial data from host
	output byte_t rx_byte_o,
	output logic  rx_byte_stb_o,      // One cycle, at stop bit midpoint
	output logic  rx_frame_err_stb_o  // Stop bit sampled low
);

	//////////////////////////////////////////////////
	// Synchroniser and start edge
	//////////////////////////////////////////////////

	logic [1:0] rx_sync_q; // Two stages, reset to idle level
	logic       rx_prev_q;
	logic       rx_bit;

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			rx_sync_q <= 2'b11;
			rx_prev_q <= 1'b1;
		end
		else
		begin
			rx_sync_q <= {rx_sync_q[0], uart_rx_i};
			rx_prev_q <= rx_sync_q[1]; // Previous synced level for edge detect
		end
	end

	assign rx_bit = rx_sync_q[1];

	//////////////////////////////////////////////////
	// Bit sampler
	//////////////////////////////////////////////////

	logic                      busy_q;
	logic [BAUD_BITS-1:0]      baud_cnt_q; // Clocks to next mid-bit
	logic [FRAME_CNT_BITS-1:0] bit_cnt_q;  // 0 start, 1..8 data, 9 stop
	byte_t                     data_q;
	logic                      sample;
	logic                      stop_bit;

	assign sample   = busy_q && (baud_cnt_q == '0);
	assign stop_bit = (bit_cnt_q == FRAME_CNT_BITS'(FRAME_BITS - 1));

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			busy_q     <= 1'b0;
			baud_cnt_q <= '0;
			bit_cnt_q  <= '0;
		end
		else if (!busy_q)
		begin
			if (rx_prev_q && !rx_bit) // Falling edge, start bit begins
			begin
				busy_q     <= 1'b1;
				baud_cnt_q <= BAUD_BITS'(BAUD_PERIOD / 2 - 1); // Half bit to midpoint
				bit_cnt_q  <= '0;
			end
		end
		else if (baud_cnt_q != '0)
			baud_cnt_q <= baud_cnt_q - 1'b1;
		else
		begin
			baud_cnt_q <= BAUD_BITS'(BAUD_PERIOD - 1);
			bit_cnt_q  <= bit_cnt_q + 1'b1;
			// Start bit gone high at mid-bit is a glitch
			if ((bit_cnt_q == '0 && rx_bit) || stop_bit)
				busy_q <= 1'b0;
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk_i)
	begin
		if (sample && (bit_cnt_q != '0) && !stop_bit)
			data_q <= {rx_bit, data_q[7:1]};
	end

	assign rx_byte_o          = data_q;
	assign rx_byte_stb_o      = sample && stop_bit && rx_bit;
	assign rx_frame_err_stb_o = sample && stop_bit && !rx_bit;

	// Either outcome of a frame ends it and frees the sampler
	a_frame_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(rx_byte_stb_o || rx_frame_err_stb_o) |=> !busy_q);

endmodule

/* rtl/bridge_pkg.sv */
/*
 * Packet, UART timing and LED constants shared by the bridge.
 * BAUD_PERIOD must stay below 2**BAUD_BITS.
 */

package bridge_pkg;

	//////////////////////////////////////////////////
	// Packets and link channels
	//////////////////////////////////////////////////

	localparam int PKT_BYTES = 5;
	localparam int PKT_BITS  = PKT_BYTES * 8; // 40 bits on the link

	typedef logic [PKT_BITS-1:0] pkt_t;
	typedef logic [7:0]          byte_t;

	localparam int NUM_CHANS = 8;
	localparam int CHAN_BITS = $clog2(NUM_CHANS);

	typedef logic [CHAN_BITS-1:0] chan_t; // Only channel 0 reaches the host

	localparam int BYTE_CNT_BITS = $clog2(PKT_BYTES);

	//////////////////////////////////////////////////
	// UART timing
	//////////////////////////////////////////////////

	localparam int BAUD_PERIOD    = 25; // Clocks per bit
	localparam int BAUD_BITS      = $clog2(BAUD_PERIOD);
	localparam int FRAME_BITS     = 10; // Start, 8 data, stop
	localparam int FRAME_CNT_BITS = $clog2(FRAME_BITS);

	// Host-to-link buffer
	localparam int RX_FIFO_ADDR_BITS  = 4; // 16 packets
	localparam int RX_HIGH_WATER_MARK = 8; // CTS removed from here up

	//////////////////////////////////////////////////
	// Status LEDs
	//////////////////////////////////////////////////

	localparam int ACTIVITY_TIMEOUT = 2048; // Clocks of hold after last transfer
	localparam int ACTIVITY_BITS    = $clog2(ACTIVITY_TIMEOUT + 1);
	localparam int BLINK_BIT        = 5;    // 64 clock blink period

endpackage
